//--- src/issue_pkg.sv
// issue stage package: opcodes, split state and the decode/issue structs
package issue_pkg;

    // encoding of nop (andi r0, r0, 0), fills an empty lane
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // micro-op of one decoded instruction
    typedef enum logic [3:0] {
        UOP_NOP     = 4'd0,
        UOP_ADD     = 4'd1,
        UOP_SUB     = 4'd2,
        UOP_AND     = 4'd3,
        UOP_OR      = 4'd4,
        UOP_MUL     = 4'd5,  // pairs with an alu op
        UOP_LD      = 4'd6,  // pairs with an alu op
        UOP_ST      = 4'd7,
        UOP_BR      = 4'd8,
        UOP_SYSCALL = 4'd9,  // syscall and break
        UOP_PRIV    = 4'd10
    } uop_e;

    // second beat of a split pair pending or not
    typedef enum logic {
        ST_PAIR   = 1'b0,
        ST_SECOND = 1'b1
    } split_state_e;

    // one decoded instruction, 144 bits
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        uop_e        uop;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic        excp;
        logic [6:0]  excp_code;
        logic        taken;      // predicted-taken branch
        logic [19:0] pad;
    } inst_t;

    typedef struct packed {
        inst_t slot0;
        inst_t slot1;
    } decode_pair_t;

    typedef struct packed {
        inst_t lane0;
        inst_t lane1;
        logic  lane1_valid;
        logic  single;           // one instruction this beat
    } issue_bundle_t;

endpackage

//--- src/decode_pair_reg.sv
// decode pair register: holds one decoded pair until the issue logic consumes it
`timescale 1ns/1ns

module decode_pair_reg
    import issue_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         flush,

    // from decode
    input  logic         in_valid,
    input  decode_pair_t in_pair,
    output logic         in_allowin,

    // toward the pairing logic
    output logic         pair_valid,
    output decode_pair_t pair,
    input  logic         pair_consume
);

    logic in_fire;

    // empty, or emptied this cycle, so streaming keeps full rate
    assign in_allowin = !pair_valid || pair_consume;
    assign in_fire    = in_valid && in_allowin;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pair_valid <= 1'b0;
        end else if (flush) begin
            pair_valid <= 1'b0;
        end else if (in_allowin) begin
            pair_valid <= in_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (in_fire) begin
            pair <= in_pair;
        end
    end

endmodule

//--- src/dual_issue_ctrl.sv
// dual issue control: pairs or splits a decoded pair and drops the shadow of a taken branch
`timescale 1ns/1ns

module dual_issue_ctrl
    import issue_pkg::*;
#(
    parameter int ALLOW_DUAL = 1
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,

    // from the pair register
    input  logic          pair_valid,
    input  decode_pair_t  pair,
    output logic          pair_consume,

    // toward the output register
    output logic          iss_valid,
    output issue_bundle_t iss_bundle,
    input  logic          iss_allowin
);

    split_state_e state;
    split_state_e state_nxt;

    logic  class_ok;
    logic  hazard;
    logic  any_excp;
    logic  nop1;
    logic  can_dual;
    logic  drop;
    inst_t nop_lane;

    function automatic logic is_alu(input uop_e uop);
        return uop inside {UOP_ADD, UOP_SUB, UOP_AND, UOP_OR};
    endfunction

    // mul and ld may sit next to a simple alu op
    function automatic logic is_alu_mate(input uop_e uop);
        return uop inside {UOP_MUL, UOP_LD};
    endfunction

    function automatic logic writes_rd(input inst_t i);
        return (is_alu(i.uop) || is_alu_mate(i.uop)) && (i.rd != 5'd0);
    endfunction

    function automatic logic reads_reg(input inst_t i, input logic [4:0] r);
        return (i.rj == r) || (i.rk == r);
    endfunction

    assign class_ok = (is_alu(pair.slot0.uop) && is_alu(pair.slot1.uop))
                   || (is_alu(pair.slot0.uop) && is_alu_mate(pair.slot1.uop))
                   || (is_alu_mate(pair.slot0.uop) && is_alu(pair.slot1.uop));

    // raw and war inside the pair, r0 never counts
    assign hazard = (writes_rd(pair.slot0) && reads_reg(pair.slot1, pair.slot0.rd))
                 || (writes_rd(pair.slot1) && reads_reg(pair.slot0, pair.slot1.rd));

    assign any_excp = pair.slot0.excp || pair.slot1.excp;
    assign nop1     = (pair.slot1.uop == UOP_NOP);

    assign can_dual = (ALLOW_DUAL != 0) && class_ok && !hazard && !any_excp && !nop1;

    // shadow of a taken branch is never issued
    assign drop = (state == ST_SECOND) && pair.slot0.taken;

    always_comb begin
        nop_lane      = '0;
        nop_lane.inst = INST_NOP;
        nop_lane.uop  = UOP_NOP;
    end

    always_comb begin
        iss_bundle             = '0;
        iss_bundle.lane1       = nop_lane;
        iss_bundle.lane1_valid = 1'b0;
        iss_bundle.single      = 1'b1;
        iss_valid              = 1'b0;
        pair_consume           = 1'b0;
        case (state)
            ST_PAIR: begin
                iss_valid        = pair_valid;
                iss_bundle.lane0 = pair.slot0;
                if (can_dual) begin
                    iss_bundle.lane1       = pair.slot1;
                    iss_bundle.lane1_valid = 1'b1;
                    iss_bundle.single      = 1'b0;
                    pair_consume           = pair_valid && iss_allowin;
                end
            end
            ST_SECOND: begin
                iss_valid        = pair_valid && !drop;
                iss_bundle.lane0 = pair.slot1;
                pair_consume     = pair_valid && (drop || iss_allowin);
            end
            default: begin
                iss_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_PAIR: begin
                if (pair_valid && iss_allowin && !can_dual) begin
                    state_nxt = ST_SECOND;   // slot0 left alone
                end
            end
            ST_SECOND: begin
                if (pair_consume) begin
                    state_nxt = ST_PAIR;
                end
            end
            default: begin
                state_nxt = ST_PAIR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_PAIR;
        end else if (flush) begin
            state <= ST_PAIR;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- src/issue_out_reg.sv
// issue output register: pipeline register toward register read, holds under back-pressure
`timescale 1ns/1ns

module issue_out_reg
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,

    // from the pairing logic
    input  logic          iss_valid,
    input  issue_bundle_t iss_bundle,
    output logic          iss_allowin,

    // toward register read
    output logic          out_valid,
    output issue_bundle_t out_bundle,
    input  logic          out_allowin
);

    logic load;

    // free slot, or the current beat leaves this cycle
    assign iss_allowin = !out_valid || out_allowin;
    assign load        = iss_valid && iss_allowin;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (iss_allowin) begin
            out_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_bundle <= iss_bundle;   // held while stalled
        end
    end

endmodule

//--- src/issue_top.sv
// issue stage top: pair register, dual issue control and output register
`timescale 1ns/1ns

module issue_top
    import issue_pkg::*;
#(
    parameter int ALLOW_DUAL = 1
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,

    input  logic          in_valid,
    input  decode_pair_t  in_pair,
    output logic          in_allowin,

    output logic          out_valid,
    output issue_bundle_t out_bundle,
    input  logic          out_allowin
);

    logic          pair_valid;
    decode_pair_t  pair;
    logic          pair_consume;
    logic          iss_valid;
    issue_bundle_t iss_bundle;
    logic          iss_allowin;

    decode_pair_reg decode_pair_reg_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_pair      (in_pair),
        .in_allowin   (in_allowin),
        .pair_valid   (pair_valid),
        .pair         (pair),
        .pair_consume (pair_consume)
    );

    dual_issue_ctrl #(
        .ALLOW_DUAL (ALLOW_DUAL)
    ) dual_issue_ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .pair_valid   (pair_valid),
        .pair         (pair),
        .pair_consume (pair_consume),
        .iss_valid    (iss_valid),
        .iss_bundle   (iss_bundle),
        .iss_allowin  (iss_allowin)
    );

    issue_out_reg issue_out_reg_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .iss_valid   (iss_valid),
        .iss_bundle  (iss_bundle),
        .iss_allowin (iss_allowin),
        .out_valid   (out_valid),
        .out_bundle  (out_bundle),
        .out_allowin (out_allowin)
    );

endmodule

//--- tb/issue_tb_table.svh
// issue stage test table: instruction pairs with their expected issue pattern
`ifndef ISSUE_TB_TABLE_SVH
`define ISSUE_TB_TABLE_SVH

typedef enum {PAT_DUAL, PAT_SPLIT, PAT_DROP, PAT_ANY} pat_e;

string        row_name[$];
decode_pair_t row_pair[$];
pat_e         row_pat[$];
bit           row_rnd[$];    // register numbers come from the lcg
bit           row_flush[$];  // flush between the two beats

function automatic inst_t mk_inst(uop_e uop, int rd, int rj, int rk, int excp, int taken);
    inst_t i;
    i           = '0;
    i.uop       = uop;
    i.inst      = {28'h0000_001, uop};
    i.rd        = 5'(rd);
    i.rj        = 5'(rj);
    i.rk        = 5'(rk);
    i.excp      = (excp != 0);
    i.excp_code = (excp != 0) ? 7'h0b : 7'h00;
    i.taken     = (taken != 0);
    return i;
endfunction

task automatic add_row(string name, inst_t s0, inst_t s1, pat_e pat, bit rnd, bit fl);
    decode_pair_t p;
    int idx;
    idx        = row_name.size();
    p.slot0    = s0;
    p.slot1    = s1;
    p.slot0.pc = 32'h0000_1000 + idx * 8;
    p.slot1.pc = 32'h0000_1004 + idx * 8;
    p.slot0.imm = idx;
    p.slot1.imm = idx + 1;
    row_name.push_back(name);
    row_pair.push_back(p);
    row_pat.push_back(pat);
    row_rnd.push_back(rnd);
    row_flush.push_back(fl);
endtask

task automatic build_table();
    add_row("alu_pair", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_SUB, 4, 5, 6, 0, 0),
            PAT_DUAL, 0, 0);
    add_row("raw", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_SUB, 4, 1, 6, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("war", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_OR, 2, 5, 6, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("excp", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_SUB, 4, 5, 6, 1, 0),
            PAT_SPLIT, 0, 0);
    add_row("syscall", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_SYSCALL, 0, 0, 0, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("priv", mk_inst(UOP_PRIV, 0, 0, 0, 0, 0), mk_inst(UOP_ADD, 7, 8, 9, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("nop_slot1", mk_inst(UOP_AND, 3, 4, 5, 0, 0), mk_inst(UOP_NOP, 0, 0, 0, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("br_taken", mk_inst(UOP_BR, 0, 1, 2, 0, 1), mk_inst(UOP_ADD, 3, 4, 5, 0, 0),
            PAT_DROP, 0, 0);
    add_row("br_not_taken", mk_inst(UOP_BR, 0, 1, 2, 0, 0), mk_inst(UOP_ADD, 3, 4, 5, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("alu_mul", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_MUL, 4, 5, 6, 0, 0),
            PAT_DUAL, 0, 0);
    add_row("ld_alu", mk_inst(UOP_LD, 10, 11, 0, 0, 0), mk_inst(UOP_SUB, 12, 13, 14, 0, 0),
            PAT_DUAL, 0, 0);
    add_row("mul_mul", mk_inst(UOP_MUL, 1, 2, 3, 0, 0), mk_inst(UOP_MUL, 4, 5, 6, 0, 0),
            PAT_SPLIT, 0, 0);
    add_row("r0_write", mk_inst(UOP_ADD, 0, 1, 2, 0, 0), mk_inst(UOP_SUB, 3, 0, 4, 0, 0),
            PAT_DUAL, 0, 0);
    add_row("flush_mid", mk_inst(UOP_ADD, 1, 2, 3, 0, 0), mk_inst(UOP_ST, 0, 4, 5, 0, 0),
            PAT_SPLIT, 0, 1);
    add_row("after_flush", mk_inst(UOP_OR, 6, 7, 8, 0, 0), mk_inst(UOP_ADD, 9, 10, 11, 0, 0),
            PAT_DUAL, 0, 0);
    for (int k = 0; k < 8; k++) begin
        add_row($sformatf("rand_%0d", k), mk_inst(UOP_ADD, 0, 0, 0, 0, 0),
                mk_inst(UOP_SUB, 0, 0, 0, 0, 0), PAT_ANY, 1, 0);
    end
endtask

`endif

//--- tb/issue_tb.sv
// issue stage testbench: table driven pairs, reference model and random back-pressure
`timescale 1ns/1ns

module issue_tb
    import issue_pkg::*;
;
    logic          clk;
    logic          rstn;
    logic          flush;
    logic          in_valid;
    decode_pair_t  in_pair;
    logic          in_allowin;
    logic          out_valid;
    issue_bundle_t out_bundle;
    logic          out_allowin;

    logic [31:0]   lcg_state;
    bit            force_allow;
    bit            table_ready;
    bit            hold_pending;
    issue_bundle_t hold_bundle;
    issue_bundle_t exp_q[$];
    string         exp_name[$];

    `include "issue_tb_table.svh"

    issue_top #(.ALLOW_DUAL(1)) issue_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_pair     (in_pair),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_bundle  (out_bundle),
        .out_allowin (out_allowin)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bundle(string name, issue_bundle_t exp, issue_bundle_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_allowin(string name, bit exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic bit is_alu(uop_e u);
        return (u == UOP_ADD) || (u == UOP_SUB) || (u == UOP_AND) || (u == UOP_OR);
    endfunction

    // expected beats of one pair, built from the pairing rules
    task automatic model_pair(decode_pair_t p, output int n, output issue_bundle_t b0,
                              output issue_bundle_t b1);
        inst_t nop;
        bit    cls;
        bit    hz;
        bit    mate0;
        bit    mate1;
        nop      = '0;
        nop.inst = INST_NOP;
        nop.uop  = UOP_NOP;
        mate0 = (p.slot0.uop == UOP_MUL) || (p.slot0.uop == UOP_LD);
        mate1 = (p.slot1.uop == UOP_MUL) || (p.slot1.uop == UOP_LD);
        cls = (is_alu(p.slot0.uop) && (is_alu(p.slot1.uop) || mate1))
           || (mate0 && is_alu(p.slot1.uop));
        hz = ((p.slot0.rd != 0) && ((p.slot1.rj == p.slot0.rd) || (p.slot1.rk == p.slot0.rd)))
          || ((p.slot1.rd != 0) && ((p.slot0.rj == p.slot1.rd) || (p.slot0.rk == p.slot1.rd)));
        b0 = {p.slot0, nop, 1'b0, 1'b1};
        b1 = {p.slot1, nop, 1'b0, 1'b1};
        if (cls && !hz && !p.slot0.excp && !p.slot1.excp && p.slot1.uop != UOP_NOP) begin
            b0 = {p.slot0, p.slot1, 1'b1, 1'b0};
            n  = 1;
        end else if (p.slot0.taken) begin
            n = 1;   // shadow dropped
        end else begin
            n = 2;
        end
    endtask

    task automatic expect_row(int i, bit first_only);
        issue_bundle_t b0;
        issue_bundle_t b1;
        int n;
        bit ok;
        model_pair(row_pair[i], n, b0, b1);
        case (row_pat[i])
            PAT_DUAL:  ok = (n == 1) && !b0.single;
            PAT_SPLIT: ok = (n == 2);
            PAT_DROP:  ok = (n == 1) && b0.single;
            default:   ok = 1'b1;
        endcase
        if (!ok) begin
            fail_run($sformatf("model and table disagree on the pattern of row %s", row_name[i]));
        end
        exp_q.push_back(b0);
        exp_name.push_back({row_name[i], " beat0"});
        if (n == 2 && !first_only) begin
            exp_q.push_back(b1);
            exp_name.push_back({row_name[i], " beat1"});
        end
    endtask

    // called at a rising edge, returns at the accepting edge
    task automatic send_pair(int i);
        expect_row(i, 1'b0);
        in_pair  <= row_pair[i];
        in_valid <= 1'b1;
        do @(negedge clk); while (!in_allowin);
        @(posedge clk);
    endtask

    task automatic drain();
        do @(negedge clk); while (exp_q.size() != 0);
        @(posedge clk);
    endtask

    task automatic send_flush_row(int i);
        in_valid <= 1'b0;        // previous pair already taken
        drain();
        force_allow <= 1'b1;
        @(posedge clk);
        expect_row(i, 1'b1);
        in_pair  <= row_pair[i];
        in_valid <= 1'b1;
        @(negedge clk);
        check_allowin({row_name[i], " in_allowin"}, 1'b1, in_allowin);
        @(posedge clk);          // pair accepted
        in_valid <= 1'b0;
        @(posedge clk);          // first beat loaded
        flush <= 1'b1;
        @(posedge clk);
        flush       <= 1'b0;
        force_allow <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (force_allow) begin
            out_allowin <= 1'b1;
        end else begin
            out_allowin <= (lcg_next() & 32'h3) != 32'h0;   // stall about a quarter of cycles
        end
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (hold_pending) begin
                if (!out_valid) begin
                    fail_run("out_valid dropped while register read was stalling");
                end
                check_bundle("hold under back-pressure", hold_bundle, out_bundle);
            end
            hold_pending = out_valid && !out_allowin;
            hold_bundle  = out_bundle;
            if (out_valid && out_allowin) begin
                if (exp_q.size() == 0) begin
                    fail_run("issue beat seen with no beat expected");
                end
                check_bundle(exp_name[0], exp_q[0], out_bundle);
                void'(exp_q.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (row_name.size() * 20 + 8) @(posedge clk);
        fail_run("timeout waiting for issue output");
    end

    initial begin
        logic [31:0] r;
        rstn         = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_pair      = '0;
        out_allowin  = 1'b0;
        force_allow  = 1'b0;
        hold_pending = 1'b0;
        lcg_state    = 32'd85137;
        build_table();
        for (int i = 0; i < row_name.size(); i++) begin
            if (row_rnd[i]) begin
                r = lcg_next();
                r = (r << 16) | lcg_next();   // two draws give 32 usable bits
                row_pair[i].slot0.rd = {2'b00, r[2:0]};
                row_pair[i].slot0.rj = {2'b00, r[5:3]};
                row_pair[i].slot0.rk = {2'b00, r[8:6]};
                row_pair[i].slot1.rd = {2'b00, r[11:9]};
                row_pair[i].slot1.rj = {2'b00, r[14:12]};
                row_pair[i].slot1.rk = {2'b00, r[17:15]};
                row_pair[i].slot1.uop = r[18] ? UOP_MUL : UOP_SUB;
            end
        end
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_allowin("in_allowin after reset", 1'b1, in_allowin);
        check_allowin("out_valid after reset", 1'b0, out_valid);
        @(posedge clk);
        for (int i = 0; i < row_name.size(); i++) begin
            if (row_flush[i]) begin
                send_flush_row(i);
            end else begin
                send_pair(i);
            end
        end
        in_valid <= 1'b0;
        drain();
        repeat (6) @(negedge clk);
        if (out_valid || !in_allowin) begin
            fail_run("issue stage not idle after the last row");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+tb
src/issue_pkg.sv
src/decode_pair_reg.sv
src/dual_issue_ctrl.sv
src/issue_out_reg.sv
src/issue_top.sv
tb/issue_tb.sv

//--- Makefile
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= issue_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
